//--- verification/ctrl_stim.txt
// kind arg data. 1 program word data at arg, 2 run_start, 3 register arg reads data,
// 4 arg pulses so far and data last word other than PAUSE, 5 all registers read data
1 000 31123400  // ADDI r1 = 1234
1 001 32F00F00  // ADDI r2 = F00F
1 002 83000012  // ADD  r3 = r1 + r2, wraps
1 003 21000020  // XOR  r1 ^= r2
1 004 F0000000  // PAUSE
1 005 89000012  // ADD  r9 = r1 + r2 on kept values
1 006 36000500  // ADDI r6 = 5, loop bound
1 007 37000170  // ADDI r7 = r7 + 1
1 008 38000170  // ADDI r8 = r7 + 1
1 009 46000080  // BGE  r6, r8
1 00A 50000700  // JUMP 7
1 00B 92ABCD34  // LOADB, data side only
1 00C F0000000  // PAUSE
1 00D 46000070  // BGE  r6, r7 sets the flag
1 00E 10000000  // END
1 00F 50001100  // JUMP 11, flag cleared so not taken
1 010 F0000000  // PAUSE
1 011 3A007700  // ADDI r10 = 77, only on a taken jump
1 012 F0000000  // PAUSE
2 0 0           // Arithmetic
3 1 E23B
3 3 0243
2 0 0           // Resume, then loop
3 9 D24A
3 7 0005
4 1D 92ABCD34   // 29 pulses
2 0 0           // Flag set, then END
5 0 0000
2 0 0           // JUMP after END
4 21 50001100   // 33 pulses

//--- list.f
design/ctrl_pkg.sv
design/instr_rom.sv
design/program_counter.sv
design/ctrl_sequencer.sv
design/reg_file.sv
design/execute_unit.sv
design/wb_host_port.sv
design/ctrl_top.sv
verification/ctrl_assert.sv
verification/tb_ctrl_top.sv

//--- verification/tb_ctrl_top.sv
module tb_ctrl_top import ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int STIM_WORDS = 3 * 64;     // Three columns per record

    logic        clk_in = 1'b0;
    logic        rst_in;
    logic        run_start;
    logic        run_busy;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    issue_t      issue;

    logic [31:0] stim [STIM_WORDS] = '{default: '0};   // Kind 0 ends the list
    int          issue_count = 0;
    instr_t      last_instr  = '0;                      // Last issued word other than PAUSE
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          checks_done = 0;
    reg_word_t   shadow [REG_COUNT] = '{default: '0};   // Register file model, zero after reset

    ctrl_top ctrl_top_i (.*);

    always #10 clk_in = ~clk_in;                        // 20 ns period

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_reg(input string name, input reg_word_t got, input reg_word_t exp);
        checks_done++;
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_instr(input string name, input instr_t got, input instr_t exp);
        checks_done++;
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks_done++;
        if (got != exp) begin
            stop_with_failure($sformatf("Mismatch at %0t: %s is %0d, expected %0d",
                                        $time, name, got, exp));
        end
    endtask

    // Register effect of one executed instruction
    task automatic update_shadow(input instr_t ins);
        case (ins.opcode)
            OP_XOR:  shadow[ins.reg_a] = shadow[ins.reg_a] ^ shadow[ins.reg_b];
            OP_ADDI: shadow[ins.reg_a] = ins.imm + shadow[ins.reg_b];   // Mod 2^16
            OP_ADD:  shadow[ins.reg_a] = shadow[ins.reg_b] + shadow[ins.reg_c];
            OP_END: begin
                for (int i = 0; i < REG_COUNT; i++) begin
                    shadow[i] = '0;
                end
            end
            default: ;          // No register write
        endcase
    endtask

    // ------------------------------------------------------------------------
    // Wishbone classic master, hold the request until ack
    // ------------------------------------------------------------------------
    task automatic wb_transfer(input logic we, input wb_addr_t addr, input wb_data_t dat,
                               output wb_data_t rdat);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, dat: dat};
        do begin
            @(negedge clk_in);
        end while (!wb_rsp.ack);
        rdat   = wb_rsp.dat;        // Registered read data lines up with ack
        wb_req = '0;
    endtask

    // One run_start pulse, then wait for END or PAUSE
    task automatic run_program();
        run_start = 1'b1;
        @(negedge clk_in);
        run_start = 1'b0;
        if (!run_busy) begin
            stop_with_failure("run_start did not move the controller out of idle");
        end
        while (run_busy) begin
            @(negedge clk_in);
        end
    endtask

    // Issue monitor, sampled mid-cycle
    always @(negedge clk_in) begin
        if (issue.valid) begin
            issue_count++;
            // Operand values as they were before this cycle's write
            check_reg("issue.val_a", issue.val_a, shadow[issue.instr.reg_a]);
            check_reg("issue.val_b", issue.val_b, shadow[issue.instr.reg_b]);
            check_reg("issue.val_c", issue.val_c, shadow[issue.instr.reg_c]);
            update_shadow(issue.instr);
            if (issue.instr.opcode != OP_PAUSE) begin
                last_instr = issue.instr;
            end
        end
    end

    always @(posedge clk_in) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_with_failure("Timeout, the tests did not finish within the cycle limit");
        end else if (ctrl_top_i.assert_i.fail_count != 0) begin
            stop_with_failure("A bound assertion failed, see the error above");
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus from file
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0] kind;
        logic [31:0] arg;
        logic [31:0] data;
        wb_data_t    rdat;
        int          max_issue;
        int          host_cycles;
        rst_in    = 1'b1;
        run_start = 1'b0;
        wb_req    = '0;
        max_issue   = 0;
        host_cycles = 0;
        $readmemh("verification/ctrl_stim.txt", stim);
        for (int r = 0; r < STIM_WORDS / 3 && stim[3 * r] != 0; r++) begin
            host_cycles += (stim[3 * r] == 32'd5) ? 4 * REG_COUNT : 4;
            if (stim[3 * r] == 32'd4 && int'(stim[3 * r + 1]) > max_issue) begin
                max_issue = int'(stim[3 * r + 1]);     // Issue total grows run by run
            end
        end
        cycle_limit = 3 * max_issue + host_cycles + 10 + 40;   // Three cycles each, reset
        repeat (10) @(negedge clk_in);
        rst_in = 1'b0;
        for (int r = 0; r < STIM_WORDS / 3 && stim[3 * r] != 0; r++) begin
            kind = stim[3 * r];
            arg  = stim[3 * r + 1];
            data = stim[3 * r + 2];
            case (kind)
                1: wb_transfer(1'b1, wb_addr_t'(arg), data, rdat);  // Program word
                2: run_program();
                3: begin
                    wb_transfer(1'b0, wb_addr_t'((1 << REG_SPACE_BIT) | arg), '0, rdat);
                    check_reg($sformatf("r%0d", arg), reg_word_t'(rdat), reg_word_t'(data));
                end
                4: begin
                    check_count("issue count", issue_count, int'(arg));
                    check_instr("last issued instr", last_instr, instr_t'(data));
                end
                5: begin
                    for (int i = 0; i < REG_COUNT; i++) begin
                        wb_transfer(1'b0, wb_addr_t'((1 << REG_SPACE_BIT) | i), '0, rdat);
                        check_reg($sformatf("r%0d", i), reg_word_t'(rdat), reg_word_t'(data));
                    end
                end
                default: stop_with_failure("Unknown record kind in the stimulus file");
            endcase
        end
        if (checks_done > 0 && ctrl_top_i.assert_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_with_failure("No checks ran, or a bound assertion failed");
        end
    end

endmodule

//--- verification/ctrl_assert.sv
module ctrl_assert import ctrl_pkg::*; (
    input logic    clk_in,
    input logic    rst_in,
    input logic    run_busy,
    input wb_req_t wb_req,
    input wb_rsp_t wb_rsp,
    input issue_t  issue
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;         // Seen by the testbench at the end

    task automatic note_failure(input string what);
        $error("%s", what);
        fail_count++;
    endtask

    ack_after_req: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(wb_rsp.ack) |-> $past(wb_req.cyc && wb_req.stb))
        else note_failure("Wishbone ack raised without cyc and stb");

    ack_one_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        wb_rsp.ack |=> !wb_rsp.ack)
        else note_failure("Wishbone ack held for more than one cycle");

    issue_one_cycle: assert property (@(posedge clk_in) disable iff (rst_in)
        issue.valid |=> !issue.valid)
        else note_failure("issue valid held for two cycles");

    // Controller waits in idle for the host
    idle_after_reset: assert property (@(posedge clk_in) rst_in |=> !run_busy)
        else note_failure("run_busy high right after reset");

endmodule

bind ctrl_top ctrl_assert assert_i (.clk_in, .rst_in, .run_busy, .wb_req, .wb_rsp, .issue);

//--- design/ctrl_top.sv
module ctrl_top import ctrl_pkg::*; (
    input  logic    clk_in,
    input  logic    rst_in,
    input  logic    run_start,
    output logic    run_busy,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output issue_t  issue       // One pulse per executed instruction
);

    // Host side
    reg_idx_t  host_reg_idx;
    reg_word_t host_reg_val;
    logic      prog_we;
    pc_t       prog_addr;
    instr_t    prog_data;

    // Fetch and sequencing
    pc_t       pc;
    instr_t    instr;
    logic      fetch_start, fetch_done, pc_advance, exec_en;

    // Execute
    reg_word_t val_a, val_b, val_c;
    logic      wr_en, clear_all, jump_take, halt;
    reg_idx_t  wr_idx;
    reg_word_t wr_data;
    pc_t       jump_target;

    wb_host_port host_port_i (
        .clk_in, .rst_in, .wb_req, .wb_rsp, .run_busy,
        .host_reg_idx, .host_reg_val, .prog_we, .prog_addr, .prog_data
    );

    instr_rom rom_i (
        .clk_in, .pc, .prog_we, .prog_addr, .prog_data, .instr
    );

    program_counter pc_i (
        .clk_in, .rst_in, .fetch_start, .pc_advance,
        .jump_take, .jump_target, .pc, .fetch_done
    );

    ctrl_sequencer seq_i (
        .clk_in, .rst_in, .run_start, .fetch_done, .halt,
        .fetch_start, .pc_advance, .exec_en, .run_busy
    );

    reg_file regs_i (
        .clk_in, .rst_in,
        .rd_a(instr.reg_a), .rd_b(instr.reg_b), .rd_c(instr.reg_c),
        .host_reg_idx, .val_a, .val_b, .val_c, .host_reg_val,
        .wr_en, .wr_idx, .wr_data, .clear_all
    );

    execute_unit exec_i (
        .clk_in, .rst_in, .exec_en, .instr, .val_a, .val_b, .val_c,
        .wr_en, .wr_idx, .wr_data, .clear_all, .jump_take, .halt, .jump_target
    );

    // Issue carries pre-write register values
    assign issue = '{valid: exec_en, instr: instr, val_a: val_a, val_b: val_b, val_c: val_c};

endmodule

//--- design/wb_host_port.sv
module wb_host_port import ctrl_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    input  logic      run_busy,
    output reg_idx_t  host_reg_idx,
    input  reg_word_t host_reg_val,
    output logic      prog_we,
    output pc_t       prog_addr,
    output instr_t    prog_data
);

    logic     ack;
    wb_data_t rd_dat;          // Registered read data
    logic     req_new;         // Request not yet acknowledged
    logic     reg_space;

    assign req_new   = wb_req.cyc && wb_req.stb && !ack;
    assign reg_space = wb_req.addr[REG_SPACE_BIT];

    // Program writes are dropped during a run, still acked
    assign prog_we      = req_new && wb_req.we && !reg_space && !run_busy;
    assign prog_addr    = wb_req.addr[$bits(pc_t)-1:0];
    assign prog_data    = instr_t'(wb_req.dat);
    assign host_reg_idx = wb_req.addr[$bits(reg_idx_t)-1:0];

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ack <= 1'b0;
        end else begin
            ack <= req_new;     // Single-cycle ack
        end
    end

    // No read port on program memory, so program space reads zero
    always_ff @(posedge clk_in) begin
        if (req_new && !wb_req.we) begin
            rd_dat <= reg_space ? wb_data_t'(host_reg_val) : '0;
        end
    end

    assign wb_rsp = '{ack: ack, dat: rd_dat};

endmodule

//--- design/execute_unit.sv
module execute_unit import ctrl_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  logic      exec_en,
    input  instr_t    instr,
    input  reg_word_t val_a,
    input  reg_word_t val_b,
    input  reg_word_t val_c,
    output logic      wr_en,
    output reg_idx_t  wr_idx,
    output reg_word_t wr_data,
    output logic      clear_all,
    output logic      jump_take,
    output logic      halt,
    output pc_t       jump_target
);

    logic cmp_flag;             // Set by BGE, used by JUMP

    assign wr_idx      = instr.reg_a;   // All writes go to reg_a
    assign jump_target = instr.imm[$bits(pc_t)-1:0];

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------
    always_comb begin
        wr_en     = 1'b0;
        wr_data   = '0;
        clear_all = 1'b0;
        jump_take = 1'b0;
        halt      = 1'b0;
        if (exec_en) begin
            case (instr.opcode)
                OP_XOR:   begin wr_en = 1'b1; wr_data = val_a ^ val_b; end
                OP_ADDI:  begin wr_en = 1'b1; wr_data = instr.imm + val_b; end
                OP_ADD:   begin wr_en = 1'b1; wr_data = val_b + val_c; end  // Mod 2^16
                OP_JUMP:  jump_take = cmp_flag;
                OP_END:   begin clear_all = 1'b1; halt = 1'b1; end
                OP_PAUSE: halt = 1'b1;
                default:  ;     // Data-side opcodes are NOPs here
            endcase
        end
    end

    // Compare flag
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cmp_flag <= 1'b0;
        end else if (exec_en) begin
            if (instr.opcode == OP_BGE) begin
                cmp_flag <= (val_a >= val_b);   // Unsigned
            end else if (clear_all || jump_take) begin
                cmp_flag <= 1'b0;
            end
        end
    end

endmodule

//--- design/reg_file.sv
module reg_file import ctrl_pkg::*; (
    input  logic      clk_in,
    input  logic      rst_in,
    input  reg_idx_t  rd_a,          // Issue read ports
    input  reg_idx_t  rd_b,
    input  reg_idx_t  rd_c,
    input  reg_idx_t  host_reg_idx,  // Host read port
    output reg_word_t val_a,
    output reg_word_t val_b,
    output reg_word_t val_c,
    output reg_word_t host_reg_val,
    input  logic      wr_en,
    input  reg_idx_t  wr_idx,
    input  reg_word_t wr_data,
    input  logic      clear_all      // From END
);

    reg_word_t regs [REG_COUNT];

    always_ff @(posedge clk_in) begin
        if (rst_in || clear_all) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Reads see the value before this cycle's write
    assign val_a        = regs[rd_a];
    assign val_b        = regs[rd_b];
    assign val_c        = regs[rd_c];
    assign host_reg_val = regs[host_reg_idx];

endmodule

//--- design/ctrl_sequencer.sv
module ctrl_sequencer import ctrl_pkg::*; (
    input  logic clk_in,
    input  logic rst_in,
    input  logic run_start,     // Start, or resume after PAUSE
    input  logic fetch_done,
    input  logic halt,          // END or PAUSE in execute
    output logic fetch_start,
    output logic pc_advance,
    output logic exec_en,       // Also the issue valid
    output logic run_busy
);

    seq_state_e state;

    // ------------------------------------------------------------------------
    // State register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;      // Wait for the host to load a program
        end else begin
            case (state)
                IDLE: begin
                    if (run_start) begin
                        state <= FETCH;
                    end
                end

                FETCH: begin
                    if (fetch_done) begin
                        state <= EXECUTE;   // Memory word ready next cycle
                    end
                end

                EXECUTE: begin
                    state <= halt ? IDLE : FETCH;   // One cycle only
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Control strobes
    // ------------------------------------------------------------------------

    // New fetch whenever FETCH is entered
    assign fetch_start = ((state == IDLE) && run_start)
                      || ((state == EXECUTE) && !halt);

    assign pc_advance = (state == FETCH) && fetch_done;   // pc steps as FETCH ends
    assign exec_en    = (state == EXECUTE);
    assign run_busy   = (state != IDLE);

endmodule

//--- design/program_counter.sv
module program_counter import ctrl_pkg::*; (
    input  logic clk_in,
    input  logic rst_in,
    input  logic fetch_start,   // Restart the fetch wait
    input  logic pc_advance,    // Step to next instruction
    input  logic jump_take,
    input  pc_t  jump_target,
    output pc_t  pc,
    output logic fetch_done     // High in the last fetch cycle
);

    localparam int TIMER_WIDTH = $clog2(FETCH_CYCLES + 1);

    logic [TIMER_WIDTH-1:0] fetch_timer;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            pc          <= '0;
            fetch_timer <= '0;
        end else begin
            if (jump_take) begin
                pc <= jump_target;              // Next fetch reads from target
            end else if (pc_advance) begin
                pc <= pc + pc_t'(1);            // Wraps 511 -> 0
            end

            if (fetch_start) begin
                fetch_timer <= TIMER_WIDTH'(FETCH_CYCLES - 1);
            end else if (fetch_timer != '0) begin
                fetch_timer <= fetch_timer - 1'b1;
            end
        end
    end

    // Only looked at during FETCH
    assign fetch_done = (fetch_timer == '0);

endmodule

//--- design/instr_rom.sv
module instr_rom import ctrl_pkg::*; (
    input  logic   clk_in,
    input  pc_t    pc,
    input  logic   prog_we,     // Host write strobe
    input  pc_t    prog_addr,
    input  instr_t prog_data,
    output instr_t instr        // Word at pc two edges back
);

    instr_t mem [PROG_DEPTH];
    instr_t rd_stage;           // First read register

    // Host loads the program, only while the controller is idle
    always_ff @(posedge clk_in) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Two-stage read, like a block RAM with output register
    always_ff @(posedge clk_in) begin
        rd_stage <= mem[pc];
        instr    <= rd_stage;
    end

endmodule

//--- design/ctrl_pkg.sv
package ctrl_pkg;

    // ------------------------------------------------------------------------
    // Widths and address map
    // ------------------------------------------------------------------------
    localparam int INSTR_WIDTH   = 32;
    localparam int REG_WIDTH     = 16;
    localparam int REG_COUNT     = 16;
    localparam int PROG_DEPTH    = 512;
    localparam int FETCH_CYCLES  = 2;   // Program memory read latency
    localparam int WB_ADDR_WIDTH = 10;
    localparam int REG_SPACE_BIT = 9;   // Set: register space, clear: program space

    typedef logic [REG_WIDTH-1:0]          reg_word_t;
    typedef logic [$clog2(REG_COUNT)-1:0]  reg_idx_t;
    typedef logic [REG_WIDTH-1:0]          imm_t;
    typedef logic [$clog2(PROG_DEPTH)-1:0] pc_t;
    typedef logic [WB_ADDR_WIDTH-1:0]      wb_addr_t;
    typedef logic [INSTR_WIDTH-1:0]        wb_data_t;   // Wide enough for one program word

    // Full opcode set, so the data side decodes the same values
    typedef enum logic [3:0] {
        OP_NOP       = 4'h0,
        OP_END       = 4'h1,   // Halt, clear registers and flag
        OP_XOR       = 4'h2,
        OP_ADDI      = 4'h3,
        OP_BGE       = 4'h4,   // Sets compare flag
        OP_JUMP      = 4'h5,   // Taken only with flag set
        OP_FBSWAP    = 4'h6,
        OP_LOADI     = 4'h7,
        OP_ADD       = 4'h8,
        OP_LOADB     = 4'h9,
        OP_LOAD      = 4'ha,
        OP_WRITEB    = 4'hb,
        OP_WRITE     = 4'hc,
        OP_OR        = 4'hd,
        OP_SENDITERS = 4'he,
        OP_PAUSE     = 4'hf    // Halt, state kept
    } opcode_e;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        FETCH   = 2'd1,
        EXECUTE = 2'd2
    } seq_state_e;

    // Instruction word, MSB first
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t reg_a;   // Destination / first operand
        imm_t     imm;     // Immediate or jump target
        reg_idx_t reg_b;
        reg_idx_t reg_c;
    } instr_t;

    // One executed instruction toward the data side
    typedef struct packed {
        logic      valid;
        instr_t    instr;
        reg_word_t val_a;
        reg_word_t val_b;
        reg_word_t val_c;
    } issue_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t addr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

endpackage
